/* afimux_status.f */
design/afimux_pkg.sv
design/status_pkg.sv
design/cmd_if.sv
design/chunk_ptr_table.sv
design/afimux_status.sv
design/status_generate.sv
design/status_router4.sv
design/afimux_status_top.sv
sim/tb_afimux_status.sv

/* design/afimux_pkg.sv */
/*
 * Pointer-side definitions for the memory-writer status path: sizes, pointer
 * kinds, the table address layout and the two readings of the command word.
 */
package afimux_pkg;

    localparam int ptr_width = 26;  // pointer payload bits
    localparam int num_chn   = 4;   // compressor channels
    localparam int cyc_bits  = 3;   // 8 scan cycles per channel

    // table kind codes, select code xor 1 lands on the kind
    typedef enum logic [1:0] {
        chunk_wr   = 2'd0,  // select 1
        frame_wr   = 2'd1,  // select 0, internal frame pointer
        chunk_resp = 2'd2,  // select 3
        frame_resp = 2'd3   // select 2
    } ptr_sel_e;

    typedef struct packed {
        ptr_sel_e   sel;  // bits 3:2, pointer kind
        logic [1:0] chn;  // bits 1:0, channel
    } ptr_addr_t;

    typedef struct packed {
        logic       rsvd;  // unused
        logic       set;   // field takes effect only when high
        logic [1:0] sel;   // select code
    } chan_mode_t;

    // mode writes read four channel fields, status writes read the low byte
    typedef union packed {
        chan_mode_t [num_chn-1:0] mode;
        struct packed {
            logic [7:0] rsvd;
            logic [7:0] ctrl;  // status control byte
        } st;
    } cmd_word_u;

endpackage

/* design/afimux_status.sv */
/*
 * Command decoder and pointer scanner. Keeps one select code per channel,
 * walks the pointer table round-robin and holds a rotated payload per channel
 * for the status generators.
 */
`timescale 1ns/1ps

module afimux_status (
    input  logic                             hclk,
    input  logic                             arst_n,
    cmd_if.decoder                           cmd,
    input  logic                             en,           // scan enable, low holds counter
    output afimux_pkg::ptr_addr_t            ptr_ra,       // table read address
    input  logic [afimux_pkg::ptr_width-1:0] ptr_rd,       // table read data
    output logic [3:0]                       status_wr,    // per-channel status write
    output status_pkg::status_ctrl_t         status_ctrl,  // control byte for status_wr
    output logic [afimux_pkg::ptr_width-1:0] payload [afimux_pkg::num_chn]
);

    afimux_pkg::cmd_word_u           cmd_w;                       // decoded command word
    logic [1:0]                      sel_q [afimux_pkg::num_chn];  // per-channel select
    logic [1:0]                      index;                       // channel being scanned
    logic [afimux_pkg::cyc_bits-1:0] cntr;                        // cycle within channel
    logic                            issue;                       // read slot
    logic                            issue_q;                     // table has the address
    logic                            store_q;                     // ptr_rd valid

    assign cmd_w = cmd.cmd_data;
    assign issue = en && (cntr == '0);

    // mode writes touch only fields with set high
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < afimux_pkg::num_chn; i++) begin
                sel_q[i] <= '0;
            end
        end else if (cmd.mode_we) begin
            for (int i = 0; i < afimux_pkg::num_chn; i++) begin
                if (cmd_w.mode[i].set) sel_q[i] <= cmd_w.mode[i].sel;
            end
        end
    end

    // status writes become a one-cycle strobe for channel cmd_a
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            status_wr   <= '0;
            status_ctrl <= '0;
        end else begin
            status_wr <= cmd.status_we ? (4'b0001 << cmd.cmd_a) : 4'b0000;
            if (cmd.status_we) begin
                status_ctrl <= status_pkg::status_ctrl_t'(cmd_w.st.ctrl);
            end
        end
    end

    // scan counter {index, cntr}, one read per channel every 8 cycles
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            {index, cntr} <= '0;
            ptr_ra        <= '0;
            issue_q       <= 1'b0;
            store_q       <= 1'b0;
        end else begin
            if (!en) {index, cntr} <= '0;
            else     {index, cntr} <= {index, cntr} + 1'b1;
            if (issue) begin
                ptr_ra.sel <= afimux_pkg::ptr_sel_e'(sel_q[index] ^ 2'b01);  // sel 0 -> frame_wr
                ptr_ra.chn <= index;
            end
            issue_q <= issue;
            store_q <= issue_q;
        end
    end

    // ptr_ra.chn holds until the next issue, so it names the store target
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < afimux_pkg::num_chn; i++) begin
                payload[i] <= '0;
            end
        end else if (store_q) begin
            payload[ptr_ra.chn] <= {ptr_rd[afimux_pkg::ptr_width-3:0],
                                    ptr_rd[afimux_pkg::ptr_width-1 -: 2]};  // 25:24 -> 1:0
        end
    end

    // while the scan keeps running a store lands on slot 2 of the channel it read
    a_store_slot : assert property (
        @(posedge hclk) disable iff (!arst_n)
        store_q && $past(en) |-> (cntr == 2) && (index == ptr_ra.chn)
    ) else $error("payload store off its scan slot");

endmodule

/* design/afimux_status_top.sv */
/*
 * Top level of the pointer status path: pointer table, scanner and decoder,
 * one status generator per channel and the router onto the status bus.
 */
`timescale 1ns/1ps

module afimux_status_top (
    input  logic        hclk,
    input  logic        arst_n,
    input  logic [15:0] cmd_data,      // mode fields or control byte
    input  logic [1:0]  cmd_a,         // status write channel
    input  logic        status_we,
    input  logic        mode_we,
    input  logic        en,            // scan enable
    input  logic        ptr_we,        // table write port
    input  logic [3:0]  ptr_wa,        // {kind, chn}
    input  logic [25:0] ptr_wd,
    output logic [7:0]  status_ad,     // status bus
    output logic        status_rq,
    input  logic        status_start
);

    cmd_if cmd ();

    afimux_pkg::ptr_addr_t            ptr_ra;
    logic [afimux_pkg::ptr_width-1:0] ptr_rd;
    logic [3:0]                       status_wr;
    status_pkg::status_ctrl_t         status_ctrl;
    logic [afimux_pkg::ptr_width-1:0] payload [afimux_pkg::num_chn];
    logic [7:0]                       ad_g [4];  // generator to router
    logic [3:0]                       rq_g;
    logic [3:0]                       start_g;

    assign cmd.cmd_data  = cmd_data;
    assign cmd.cmd_a     = cmd_a;
    assign cmd.status_we = status_we;
    assign cmd.mode_we   = mode_we;

    chunk_ptr_table u_table (
        .hclk(hclk), .arst_n(arst_n),
        .we(ptr_we), .wa(ptr_wa), .wd(ptr_wd),
        .ra(ptr_ra), .rd(ptr_rd)
    );

    afimux_status u_status (
        .hclk(hclk), .arst_n(arst_n), .cmd(cmd), .en(en),
        .ptr_ra(ptr_ra), .ptr_rd(ptr_rd),
        .status_wr(status_wr), .status_ctrl(status_ctrl), .payload(payload)
    );

    status_generate u_gen0 (
        .hclk(hclk), .arst_n(arst_n), .we(status_wr[0]), .ctrl(status_ctrl),
        .chn(2'd0), .payload(payload[0]), .ad(ad_g[0]), .rq(rq_g[0]), .start(start_g[0])
    );

    status_generate u_gen1 (
        .hclk(hclk), .arst_n(arst_n), .we(status_wr[1]), .ctrl(status_ctrl),
        .chn(2'd1), .payload(payload[1]), .ad(ad_g[1]), .rq(rq_g[1]), .start(start_g[1])
    );

    status_generate u_gen2 (
        .hclk(hclk), .arst_n(arst_n), .we(status_wr[2]), .ctrl(status_ctrl),
        .chn(2'd2), .payload(payload[2]), .ad(ad_g[2]), .rq(rq_g[2]), .start(start_g[2])
    );

    status_generate u_gen3 (
        .hclk(hclk), .arst_n(arst_n), .we(status_wr[3]), .ctrl(status_ctrl),
        .chn(2'd3), .payload(payload[3]), .ad(ad_g[3]), .rq(rq_g[3]), .start(start_g[3])
    );

    status_router4 u_router (
        .hclk(hclk), .arst_n(arst_n),
        .ad_in(ad_g), .rq_in(rq_g), .start_in(start_g),
        .ad_out(status_ad), .rq_out(status_rq), .start_out(status_start)
    );

endmodule

/* design/chunk_ptr_table.sv */
/*
 * Chunk pointer table, four pointer kinds for each of four channels.
 * Written from the top-level port, read by the status scanner one cycle late.
 */
`timescale 1ns/1ps

module chunk_ptr_table (
    input  logic                             hclk,
    input  logic                             arst_n,
    input  logic                             we,  // write strobe
    input  afimux_pkg::ptr_addr_t            wa,  // write address {kind, chn}
    input  logic [afimux_pkg::ptr_width-1:0] wd,  // write data
    input  afimux_pkg::ptr_addr_t            ra,  // read address
    output logic [afimux_pkg::ptr_width-1:0] rd   // read data, one cycle after ra
);

    logic [afimux_pkg::ptr_width-1:0] mem [16];  // four kinds per channel

    always_ff @(posedge hclk) begin
        if (we) begin
            mem[wa] <= wd;  // readable from next cycle on
        end
    end

    // registered read port, old data on a same-cycle write
    always_ff @(posedge hclk) begin
        rd <= mem[ra];
    end

    // a write with a floating address would corrupt an unknown entry
    a_wa_known : assert property (
        @(posedge hclk) disable iff (!arst_n)
        we |-> !$isunknown(wa)
    ) else $error("pointer table write with unknown address");

endmodule

/* design/cmd_if.sv */
/*
 * Command bus between the top-level command ports and the decoder inside the
 * status block. One data word, a channel address and two write strobes.
 */
`timescale 1ns/1ps

interface cmd_if;

    logic [15:0] cmd_data;   // mode fields or control byte
    logic [1:0]  cmd_a;      // target channel of a status write
    logic        status_we;  // status control write
    logic        mode_we;    // channel mode write

    modport source (
        output cmd_data, cmd_a, status_we, mode_we
    );

    modport decoder (
        input cmd_data, cmd_a, status_we, mode_we
    );

endinterface

/* design/status_generate.sv */
/*
 * Status packet generator for one channel. A status write sets the mode and
 * the tag; a packet goes out once per one-shot write, or on every payload
 * change in auto mode. Payload is copied at start and sent as four bytes.
 */
`timescale 1ns/1ps

module status_generate (
    input  logic                             hclk,
    input  logic                             arst_n,
    input  logic                             we,       // control write for this channel
    input  status_pkg::status_ctrl_t         ctrl,     // mode and seq tag
    input  logic [1:0]                       chn,      // own channel number
    input  logic [afimux_pkg::ptr_width-1:0] payload,  // current pointer
    output logic [7:0]                       ad,       // address, then data bytes
    output logic                             rq,       // packet request
    input  logic                             start     // address byte accepted
);

    status_pkg::status_mode_e         mode_q;     // latched mode
    logic [5:0]                       seq_q;      // latched tag
    logic [afimux_pkg::ptr_width-1:0] payload_d;  // last cycle's payload
    logic [afimux_pkg::ptr_width-1:0] pkt_q;      // payload frozen at start
    logic                             busy;       // data bytes in flight
    logic [1:0]                       cnt;        // data byte index
    logic                             is_auto;
    logic                             changed;

    assign is_auto = (mode_q == status_pkg::mode_auto) ||
                     (mode_q == status_pkg::mode_auto_alt);
    assign changed = (payload != payload_d);

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= status_pkg::mode_off;
            seq_q  <= '0;
        end else if (we) begin
            mode_q <= ctrl.mode;
            seq_q  <= ctrl.seq;
        end
    end

    always_ff @(posedge hclk) begin
        payload_d <= payload;  // change detect
        if (start) pkt_q <= payload;  // newest value wins
    end

    // new requests after the clear so a change at start is not lost
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            rq <= 1'b0;
        end else begin
            if (start) rq <= 1'b0;
            if (we && (ctrl.mode == status_pkg::mode_once)) rq <= 1'b1;
            if (is_auto && changed) rq <= 1'b1;  // merges into a pending rq
        end
    end

    // four data bytes on the cycles after start
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            if (cnt == 2'(status_pkg::pkt_bytes - 2)) busy <= 1'b0;
            cnt <= cnt + 1'b1;
        end
    end

    always_comb begin
        if (!busy) begin
            ad = status_pkg::status_base_addr + {6'b0, chn};  // address byte
        end else begin
            case (cnt)
                2'd0:    ad = {seq_q, pkt_q[1:0]};
                2'd1:    ad = pkt_q[9:2];
                2'd2:    ad = pkt_q[17:10];
                default: ad = pkt_q[25:18];
            endcase
        end
    end

    // the router must only accept a byte that was asked for
    a_start_needs_rq : assert property (
        @(posedge hclk) disable iff (!arst_n)
        start |-> rq
    ) else $error("status start while rq low");

endmodule

/* design/status_pkg.sv */
/*
 * Status packet format shared by the generators and the router: base address,
 * packet length, generator modes and the layout of the control byte.
 */
package status_pkg;

    // first of four consecutive status addresses, one per channel
    localparam logic [7:0] status_base_addr = 8'h20;

    // address byte plus four data bytes
    localparam int pkt_bytes = 5;

    typedef enum logic [1:0] {
        mode_off      = 2'd0,  // never sends
        mode_once     = 2'd1,  // one packet per status write
        mode_auto     = 2'd2,  // resend on payload change
        mode_auto_alt = 2'd3   // same as auto
    } status_mode_e;

    /*
     * control byte as written by a status command, the tag comes back in
     * the first data byte of every packet
     */
    typedef struct packed {
        logic [5:0]   seq;   // sequence tag
        status_mode_e mode;  // bits 1:0
    } status_ctrl_t;

endpackage

/* design/status_router4.sv */
/*
 * Four-to-one status router. While idle it grants round-robin from the last
 * winner and shows that generator's address byte directly; after start it
 * stays locked to the winner until the last data byte has gone by.
 */
`timescale 1ns/1ps

module status_router4 (
    input  logic       hclk,
    input  logic       arst_n,
    input  logic [7:0] ad_in [4],  // generator address/data
    input  logic [3:0] rq_in,      // generator requests
    output logic [3:0] start_in,   // start to the granted generator
    output logic [7:0] ad_out,     // merged status bus
    output logic       rq_out,
    input  logic       start_out   // downstream accepted address
);

    logic       locked;    // packet in flight
    logic [3:0] gnt_q;     // one-hot, last or current winner
    logic [1:0] cnt;       // data bytes passed
    logic [1:0] last_idx;  // index of gnt_q
    logic [3:0] nxt_gnt;   // idle grant candidate
    logic [3:0] cur_gnt;   // grant driving the bus

    always_comb begin
        last_idx = '0;
        for (int i = 0; i < 4; i++) begin
            if (gnt_q[i]) last_idx = 2'(i);
        end
    end

    // scan from far to near so last_idx + 1 has top priority
    always_comb begin
        logic [1:0] idx;
        nxt_gnt = '0;
        for (int k = 4; k >= 1; k--) begin
            idx = last_idx + 2'(k);
            if (rq_in[idx]) nxt_gnt = 4'b0001 << idx;
        end
    end

    assign cur_gnt  = locked ? gnt_q : nxt_gnt;
    assign rq_out   = !locked && (|rq_in);  // nxt_gnt covers any rq
    assign start_in = (start_out && !locked) ? nxt_gnt : 4'b0000;

    always_comb begin
        ad_out = '0;
        for (int i = 0; i < 4; i++) begin
            if (cur_gnt[i]) ad_out = ad_in[i];
        end
    end

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            locked <= 1'b0;
            gnt_q  <= 4'b1000;  // channel 0 wins first
            cnt    <= '0;
        end else if (!locked) begin
            if (start_out && (|nxt_gnt)) begin
                locked <= 1'b1;
                gnt_q  <= nxt_gnt;
                cnt    <= '0;
            end
        end else begin
            if (cnt == 2'(status_pkg::pkt_bytes - 2)) locked <= 1'b0;  // last data byte
            cnt <= cnt + 1'b1;
        end
    end

    // a packet keeps exactly one owner from start to its last byte
    a_lock_onehot : assert property (
        @(posedge hclk) disable iff (!arst_n)
        locked |-> $onehot(gnt_q) && (!$past(locked) || $stable(gnt_q))
    ) else $error("router grant not one-hot while locked");

endmodule

/* sim/afimux_stimulus.txt */
# op a b, fields in hex: N test, T addr data, M - modeword, E - en, S chn ctrl
# W - cycles, Q - quiet cycles, P - channel mask of expected packets
N 1 0  reset quiet with scan on
E 0 1
Q 0 32
N 2 0  one-shot per channel
T 0 0123456
T 1 1234567
T 2 2345678
T 3 3456789
T 4 0FEDCBA
T 5 1EDCBA9
T 6 2DCBA98
T 7 3CBA987
T 8 0A5A5A5
T 9 15A5A5A
T A 2C3C3C3
T B 33C3C3C
T C 0F0F0F0
T D 10F0F0F
T E 2E1E1E1
T F 31E1E1E
M 0 7654
W 0 28
S 0 15
P 0 1
S 1 29
P 0 2
S 2 45
P 0 4
S 3 FD
P 0 8
N 3 0  partial mode write, only chn 1 set
M 0 2173
W 0 28
S 1 2D
P 0 2
S 0 19
P 0 1
N 4 0  auto on chn 2
S 2 82
W 0 4
T E 1234ABC
P 0 4
Q 0 28
N 5 0  contention on all channels
S 0 05
S 1 09
S 2 0D
S 3 11
W 0 3
P 0 F
N 6 0  disable then enable, auto on chn 3
S 3 C2
E 0 0
T B 2223333
Q 0 28
E 0 1
P 0 8
Q 0 28

/* sim/tb_afimux_status.sv */
/*
 * Testbench for the pointer status path. Runs the command lines of the stimulus
 * file against the DUT, models the pointer table, channel selects and seq tags,
 * and checks every status packet taken off the bus against that model.
 */
`timescale 1ns/1ps

module tb_afimux_status;

    localparam int rq_timeout = 40;  // cycles allowed for a request

    logic        hclk;
    logic        arst_n;
    logic [15:0] cmd_data;
    logic [1:0]  cmd_a;
    logic        status_we;
    logic        mode_we;
    logic        en;
    logic        ptr_we;
    logic [3:0]  ptr_wa;
    logic [25:0] ptr_wd;
    logic [7:0]  status_ad;
    logic        status_rq;
    logic        status_start;

    logic [afimux_pkg::ptr_width-1:0] tbl [16];  // table model
    logic [1:0] msel [4];                        // select per channel
    logic [5:0] mseq [4];                        // last written tag
    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int test_id;     // 0 until the first test line
    int test_err0;   // errors at test start

    afimux_status_top DUT (
        .hclk(hclk), .arst_n(arst_n), .cmd_data(cmd_data), .cmd_a(cmd_a),
        .status_we(status_we), .mode_we(mode_we), .en(en),
        .ptr_we(ptr_we), .ptr_wa(ptr_wa), .ptr_wd(ptr_wd),
        .status_ad(status_ad), .status_rq(status_rq), .status_start(status_start)
    );

    initial begin
        hclk = 1'b0;
        forever #10 hclk = ~hclk;  // 20 ns
    end

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_payload(input logic [afimux_pkg::ptr_width-1:0] got,
                                 input logic [afimux_pkg::ptr_width-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: payload got %07h expected %07h", $time, got, exp);
        end
    endtask

    task automatic check_addr(input logic [7:0] got, input logic [1:0] chn);
        logic [7:0] exp;
        exp = status_pkg::status_base_addr + {6'b0, chn};  // base plus channel
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: address byte got %02h expected %02h",
                     $time, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s, at %0t", why, $time);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic finish_test();
        if (test_id != 0) begin
            tests_run++;
            if (errors == test_err0) begin
                $display("test %0d: pass", test_id);
            end else begin
                tests_failed++;
                $display("test %0d: fail, %0d errors", test_id, errors - test_err0);
            end
        end
    endtask

    task automatic write_table(input logic [3:0] a, input logic [25:0] d);
        ptr_we = 1'b1;
        ptr_wa = a;
        ptr_wd = d;
        @(negedge hclk);
        ptr_we = 1'b0;
        tbl[a] = d;
    endtask

    task automatic write_mode(input logic [15:0] w);
        cmd_data = w;
        mode_we  = 1'b1;
        @(negedge hclk);
        mode_we = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (w[4*i+2]) msel[i] = w[4*i +: 2];  // set bit guards the field
        end
    endtask

    task automatic write_status(input logic [1:0] c, input logic [7:0] ctrl);
        cmd_a     = c;
        cmd_data  = {8'h00, ctrl};
        status_we = 1'b1;
        @(negedge hclk);
        status_we = 1'b0;
        mseq[c]   = ctrl[7:2];
    endtask

    task automatic wait_for_rq();
        int t;
        t = 0;
        while (status_rq !== 1'b1) begin
            if (t == rq_timeout) abort_run("timeout: DUT never raised status_rq");
            @(negedge hclk);
            t++;
        end
    endtask

    task automatic expect_quiet(input int n);
        int bad;
        bad = 0;
        for (int i = 0; i < n; i++) begin
            @(negedge hclk);
            if (status_rq !== 1'b0) bad = 1;
        end
        checks++;
        if (bad != 0) begin
            errors++;
            $display("DUT raised status_rq during a quiet window ending at %0t", $time);
        end
    endtask

    // one packet per set bit of mask, any order
    task automatic take_packets(input logic [3:0] mask);
        logic [3:0]  pending;
        logic [7:0]  pkt [5];
        logic [7:0]  off;
        logic [1:0]  c;
        logic [3:0]  ka;
        logic [afimux_pkg::ptr_width-1:0] exp;
        int dly;
        pending = mask;
        while (pending != 4'b0000) begin
            wait_for_rq();
            dly = $urandom % 6;  // back-pressure 0..5
            for (int i = 0; i < dly; i++) begin
                @(negedge hclk);
            end
            pkt[0] = status_ad;
            status_start = 1'b1;
            for (int i = 1; i < status_pkg::pkt_bytes; i++) begin
                @(negedge hclk);
                status_start = 1'b0;
                pkt[i] = status_ad;
                if (status_rq !== 1'b0) begin
                    errors++;
                    $display("status_rq high while a packet was in flight, at %0t", $time);
                end
            end
            off = pkt[0] - status_pkg::status_base_addr;
            c = off[1:0];
            if (off > 8'd3 || !pending[c]) begin
                for (int i = 3; i >= 0; i--) begin
                    if (pending[i]) c = 2'(i);  // report against lowest pending
                end
            end
            check_addr(pkt[0], c);
            pending[c] = 1'b0;
            ka  = {msel[c] ^ 2'b01, c};               // select 0 is frame_wr
            exp = {tbl[ka][23:0], tbl[ka][25:24]};    // rotate by two
            check_byte("tag byte", pkt[1], {mseq[c], exp[1:0]});
            check_payload({pkt[4], pkt[3], pkt[2], pkt[1][1:0]}, exp);
        end
    endtask

    initial begin
        int fd;
        int n;
        string line;
        logic [7:0]  op;
        logic [31:0] fa;
        logic [31:0] fb;
        void'($urandom(64131));
        arst_n = 1'b0;
        cmd_data = '0;
        cmd_a = '0;
        status_we = 1'b0;
        mode_we = 1'b0;
        en = 1'b0;
        ptr_we = 1'b0;
        ptr_wa = '0;
        ptr_wd = '0;
        status_start = 1'b0;
        for (int i = 0; i < 4; i++) begin
            msel[i] = '0;
            mseq[i] = '0;
        end
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        test_id = 0;
        test_err0 = 0;
        repeat (16) @(negedge hclk);
        arst_n = 1'b1;
        @(negedge hclk);
        fd = $fopen("sim/afimux_stimulus.txt", "r");
        if (fd == 0) abort_run("cannot open the stimulus file sim/afimux_stimulus.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %h", op, fa, fb);
            if (n == 3 && op != "#") begin
                case (op)
                    "N": begin
                        finish_test();
                        test_id   = fa;
                        test_err0 = errors;
                    end
                    "T": write_table(fa[3:0], fb[25:0]);
                    "M": write_mode(fb[15:0]);
                    "E": begin
                        en = fb[0];
                        @(negedge hclk);
                    end
                    "S": write_status(fa[1:0], fb[7:0]);
                    "W": repeat (fb) @(negedge hclk);
                    "Q": expect_quiet(fb);
                    "P": take_packets(fb[3:0]);
                    default: abort_run("unknown command letter in the stimulus file");
                endcase
            end
        end
        $fclose(fd);
        finish_test();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
